/* logic/sdram_ctrl_pkg.sv */
package sdram_ctrl_pkg;

   // Port side
   localparam int NUM_PORTS   = 4;
   localparam int QUEUE_DEPTH = 4;
   localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

   // SDRAM timing in clock cycles
   localparam int CAS_LATENCY = 2;
   localparam int T_RCD       = 2;
   localparam int T_RP        = 2;
   localparam int T_RFC       = 7;
   localparam int T_WR_DONE   = 3;

   // Short power-up wait, enough for simulation only
   localparam int INIT_WAIT    = 20;
   localparam int REF_INTERVAL = 390;

   // READ command to response, including the two capture registers
   localparam int READ_PIPE_DEPTH = CAS_LATENCY + 2;

   localparam int WAIT_CNT_W = $clog2(INIT_WAIT);
   localparam int REF_CNT_W  = $clog2(REF_INTERVAL);

   // Auto-precharge / all-banks bit on the address pad
   localparam int AP_BIT = 10;

   // CL 2 in A6:A4, sequential burst, BL 2 in A2:A0
   localparam logic [12:0] MODE_WORD = 13'h0021;

   typedef logic [15:0]                    dq_t;
   typedef logic [31:0]                    word_t;
   typedef logic [3:0]                     be_t;
   typedef logic [1:0]                     dqm_t;
   typedef logic [1:0]                     bank_t;
   typedef logic [12:0]                    row_t;
   typedef logic [7:0]                     col_t;
   typedef logic [12:0]                    sdram_addr_t;
   typedef logic [22:0]                    word_adr_t;
   typedef logic [NUM_PORTS-1:0]           port_mask_t;
   typedef logic [$clog2(NUM_PORTS)-1:0]   port_id_t;

   // Values are {RAS_n, CAS_n, WE_n}
   typedef enum logic [2:0] {
      CMD_LOAD_MODE    = 3'b000,
      CMD_AUTO_REFRESH = 3'b001,
      CMD_PRECHARGE    = 3'b010,
      CMD_ACTIVE       = 3'b011,
      CMD_WRITE        = 3'b100,
      CMD_READ         = 3'b101,
      CMD_NOP          = 3'b111
   } sdram_cmd_t;

   typedef enum logic [3:0] {
      ST_INIT_WAIT, ST_INIT_PRE, ST_INIT_REF, ST_INIT_MODE,
      ST_IDLE, ST_REFRESH, ST_ACTIVATE, ST_ACCESS, ST_RECOVER
   } seq_state_t;

endpackage

/* logic/req_queue.sv */
`timescale 1ns/1ps

module req_queue (
   input  logic                      sdram_clk,
   input  logic                      sdram_rst,
   input  logic                      push_i,
   input  logic                      we_i,
   input  sdram_ctrl_pkg::be_t       be_i,
   input  sdram_ctrl_pkg::word_adr_t adr_i,
   input  sdram_ctrl_pkg::word_t     dat_i,
   input  logic                      pop_i,
   output logic                      empty_o,
   output logic                      full_o,
   output logic                      head_we_o,
   output sdram_ctrl_pkg::be_t       head_be_o,
   output sdram_ctrl_pkg::word_adr_t head_adr_o,
   output sdram_ctrl_pkg::word_t     head_dat_o
);
   import sdram_ctrl_pkg::*;

   logic                   mem_we  [QUEUE_DEPTH];
   be_t                    mem_be  [QUEUE_DEPTH];
   word_adr_t              mem_adr [QUEUE_DEPTH];
   word_t                  mem_dat [QUEUE_DEPTH];
   logic [QUEUE_PTR_W-1:0] wr_ptr_q;
   logic [QUEUE_PTR_W-1:0] rd_ptr_q;
   logic [QUEUE_PTR_W:0]   count_q;
   logic                   do_push;
   logic                   do_pop;

   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Entry storage
   always_ff @(posedge sdram_clk) begin
      if (do_push) begin
         mem_we[wr_ptr_q]  <= we_i;
         mem_be[wr_ptr_q]  <= be_i;
         mem_adr[wr_ptr_q] <= adr_i;
         mem_dat[wr_ptr_q] <= dat_i;
      end
   end

   assign empty_o    = (count_q == '0);
   assign full_o     = (count_q == (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
   assign head_we_o  = mem_we[rd_ptr_q];
   assign head_be_o  = mem_be[rd_ptr_q];
   assign head_adr_o = mem_adr[rd_ptr_q];
   assign head_dat_o = mem_dat[rd_ptr_q];

   // Port side must watch the full level
   assert property (@(posedge sdram_clk) disable iff (sdram_rst) push_i |-> !full_o)
      else $error("req_queue: push while full");

   // Sequencer only pops a port it saw as non-empty
   assert property (@(posedge sdram_clk) disable iff (sdram_rst) pop_i |-> !empty_o)
      else $error("req_queue: pop while empty");

endmodule

/* logic/sdram_sequencer.sv */
`timescale 1ns/1ps

module sdram_sequencer (
   input  logic                        sdram_clk,
   input  logic                        sdram_rst,
   input  sdram_ctrl_pkg::port_mask_t  queue_empty_i,
   input  logic                        head_we_i,
   input  sdram_ctrl_pkg::word_adr_t   head_adr_i,
   output sdram_ctrl_pkg::port_mask_t  pop_o,
   output sdram_ctrl_pkg::port_id_t    sel_port_o,
   output logic                        wr_load_o,
   output logic                        rd_issue_o,
   output sdram_ctrl_pkg::sdram_cmd_t  cmd_o,
   output sdram_ctrl_pkg::bank_t       ba_o,
   output sdram_ctrl_pkg::sdram_addr_t a_o
);
   import sdram_ctrl_pkg::*;

   seq_state_t            state_q;
   logic [WAIT_CNT_W-1:0] wait_q;
   logic [REF_CNT_W-1:0]  ref_cnt_q;
   logic                  refresh_req_q;
   logic                  init_ref2_q;
   port_id_t              pick;
   logic                  any_req;
   bank_t                 head_bank;
   row_t                  head_row;
   col_t                  head_col;

   assign {head_bank, head_row, head_col} = head_adr_i;

   // Fixed priority, port 0 highest
   always_comb begin
      pick = '0;
      for (int i = NUM_PORTS - 1; i >= 0; i--) begin
         if (!queue_empty_i[i]) begin
            pick = port_id_t'(i);
         end
      end
   end

   assign any_req = ~&queue_empty_i;

   // Refresh interval counter and pending request
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         ref_cnt_q     <= REF_CNT_W'(REF_INTERVAL - 1);
         refresh_req_q <= 1'b0;
      end else if (ref_cnt_q == '0) begin
         ref_cnt_q     <= REF_CNT_W'(REF_INTERVAL - 1);
         refresh_req_q <= 1'b1;
      end else begin
         ref_cnt_q <= ref_cnt_q - 1'b1;
         if (cmd_o == CMD_AUTO_REFRESH) begin
            refresh_req_q <= 1'b0;
         end
      end
   end

   // Command FSM, all pad outputs registered
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         state_q     <= ST_INIT_WAIT;
         wait_q      <= WAIT_CNT_W'(INIT_WAIT - 1);
         init_ref2_q <= 1'b0;
         sel_port_o  <= '0;
         cmd_o       <= CMD_NOP;
         ba_o        <= '0;
         a_o         <= '0;
         pop_o       <= '0;
         wr_load_o   <= 1'b0;
         rd_issue_o  <= 1'b0;
      end else begin
         // One-cycle strobes
         cmd_o      <= CMD_NOP;
         pop_o      <= '0;
         wr_load_o  <= 1'b0;
         rd_issue_o <= 1'b0;
         if (wait_q != '0) begin
            wait_q <= wait_q - 1'b1;
         end

         case (state_q)
            ST_INIT_WAIT: begin
               if (wait_q == '0) begin
                  // Precharge all banks
                  cmd_o      <= CMD_PRECHARGE;
                  a_o        <= '0;
                  a_o[AP_BIT] <= 1'b1;
                  wait_q     <= WAIT_CNT_W'(T_RP - 1);
                  state_q    <= ST_INIT_PRE;
               end
            end
            ST_INIT_PRE: begin
               if (wait_q == '0) begin
                  cmd_o   <= CMD_AUTO_REFRESH;
                  wait_q  <= WAIT_CNT_W'(T_RFC - 1);
                  state_q <= ST_INIT_REF;
               end
            end
            ST_INIT_REF: begin
               if (wait_q == '0) begin
                  if (!init_ref2_q) begin
                     cmd_o       <= CMD_AUTO_REFRESH;
                     wait_q      <= WAIT_CNT_W'(T_RFC - 1);
                     init_ref2_q <= 1'b1;
                  end else begin
                     cmd_o   <= CMD_LOAD_MODE;
                     ba_o    <= '0;
                     a_o     <= MODE_WORD;
                     state_q <= ST_INIT_MODE;
                  end
               end
            end
            ST_INIT_MODE: begin
               // The idle cycle after this covers tMRD
               state_q <= ST_IDLE;
            end
            ST_IDLE: begin
               if (refresh_req_q) begin
                  cmd_o   <= CMD_AUTO_REFRESH;
                  wait_q  <= WAIT_CNT_W'(T_RFC - 1);
                  state_q <= ST_REFRESH;
               end else if (any_req) begin
                  sel_port_o <= pick;
                  wait_q     <= WAIT_CNT_W'(T_RCD);
                  state_q    <= ST_ACTIVATE;
               end
            end
            ST_REFRESH: begin
               if (wait_q == '0) begin
                  state_q <= ST_IDLE;
               end
            end
            ST_ACTIVATE: begin
               // Head of the chosen queue is stable from here on
               if (wait_q == WAIT_CNT_W'(T_RCD)) begin
                  cmd_o <= CMD_ACTIVE;
                  ba_o  <= head_bank;
                  a_o   <= head_row;
               end else if (wait_q == '0) begin
                  cmd_o       <= head_we_i ? CMD_WRITE : CMD_READ;
                  ba_o        <= head_bank;
                  a_o         <= sdram_addr_t'({head_col, 1'b0});
                  a_o[AP_BIT] <= 1'b1;
                  pop_o       <= port_mask_t'(1) << sel_port_o;
                  wr_load_o   <= head_we_i;
                  rd_issue_o  <= !head_we_i;
                  state_q     <= ST_ACCESS;
               end
            end
            ST_ACCESS: begin
               // Writes wait out tWR, reads only the auto-precharge
               wait_q  <= wr_load_o ? WAIT_CNT_W'(T_WR_DONE - 2) : WAIT_CNT_W'(T_RP - 2);
               state_q <= ST_RECOVER;
            end
            ST_RECOVER: begin
               if (wait_q == '0) begin
                  state_q <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // A pop goes out only together with its READ or WRITE
   assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      $onehot0(pop_o) && ((pop_o != '0) == (cmd_o == CMD_READ || cmd_o == CMD_WRITE)))
      else $error("sdram_sequencer: pop not one-hot or not paired with READ/WRITE");

   // Column access always opens a row first
   assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (cmd_o == CMD_READ || cmd_o == CMD_WRITE) |-> $past(cmd_o, T_RCD) == CMD_ACTIVE)
      else $error("sdram_sequencer: READ/WRITE without ACTIVE");

endmodule

/* logic/sdram_datapath.sv */
`timescale 1ns/1ps

module sdram_datapath (
   input  logic                       sdram_clk,
   input  logic                       sdram_rst,
   input  logic                       wr_load_i,
   input  sdram_ctrl_pkg::word_t      wr_dat_i,
   input  sdram_ctrl_pkg::be_t        wr_be_i,
   input  logic                       rd_issue_i,
   input  sdram_ctrl_pkg::port_id_t   rd_port_i,
   input  sdram_ctrl_pkg::dq_t        dq_i,
   output sdram_ctrl_pkg::dq_t        dq_o,
   output logic                       dq_oe_o,
   output sdram_ctrl_pkg::dqm_t       dqm_o,
   output sdram_ctrl_pkg::port_mask_t rsp_valid_o,
   output sdram_ctrl_pkg::word_t      rsp_dat_o
);
   import sdram_ctrl_pkg::*;

   logic                       wr_beat2_q;
   logic                       wr_ack_q;
   dq_t                        wr_lo_q;
   dqm_t                       wr_lo_mask_q;
   port_id_t                   wr_port_q;
   dq_t                        dq_in_q;
   dq_t                        dq_prev_q;
   logic [READ_PIPE_DEPTH-1:0] rd_vld_q;
   port_id_t                   rd_port_q [READ_PIPE_DEPTH];
   logic                       rd_done;
   port_mask_t                 rd_mask;
   port_mask_t                 wr_mask;

   // Valid bits of the write beat and ack shift, and the read delay line
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         wr_beat2_q <= 1'b0;
         wr_ack_q   <= 1'b0;
         rd_vld_q   <= '0;
      end else begin
         wr_beat2_q <= wr_load_i;
         wr_ack_q   <= wr_beat2_q;
         rd_vld_q   <= {rd_vld_q[READ_PIPE_DEPTH-2:0], rd_issue_i};
      end
   end

   // Lower half and its mask wait for the second beat
   always_ff @(posedge sdram_clk) begin
      if (wr_load_i) begin
         wr_lo_q      <= wr_dat_i[15:0];
         wr_lo_mask_q <= ~wr_be_i[1:0];
         wr_port_q    <= rd_port_i;
      end
   end

   // rd_port_i is the selected port, sampled alongside the READ strobe
   always_ff @(posedge sdram_clk) begin
      rd_port_q[0] <= rd_port_i;
      for (int i = 1; i < READ_PIPE_DEPTH; i++) begin
         rd_port_q[i] <= rd_port_q[i-1];
      end
   end

   // Two read beats, first one ends up in the upper half
   always_ff @(posedge sdram_clk) begin
      dq_in_q   <= dq_i;
      dq_prev_q <= dq_in_q;
   end

   // Upper beat goes out with the WRITE command itself
   assign dq_o    = wr_beat2_q ? wr_lo_q : wr_dat_i[31:16];
   assign dq_oe_o = wr_load_i | wr_beat2_q;
   assign dqm_o   = wr_load_i  ? ~wr_be_i[3:2] :
                    wr_beat2_q ? wr_lo_mask_q  : '0;

   assign rd_done = rd_vld_q[READ_PIPE_DEPTH-1];
   assign rd_mask = rd_done  ? port_mask_t'(1) << rd_port_q[READ_PIPE_DEPTH-1] : '0;
   assign wr_mask = wr_ack_q ? port_mask_t'(1) << wr_port_q : '0;

   assign rsp_valid_o = rd_mask | wr_mask;
   assign rsp_dat_o   = rd_done ? {dq_prev_q, dq_in_q} : '0;

   // Sequencer spacing keeps read returns and write acks apart
   assert property (@(posedge sdram_clk) disable iff (sdram_rst) !(rd_done && wr_ack_q))
      else $error("sdram_datapath: read response collides with write ack");

endmodule

/* logic/sdram_ctrl_top.sv */
`timescale 1ns/1ps

module sdram_ctrl_top (
   input  logic                                                    sdram_clk,
   input  logic                                                    sdram_rst,
   input  sdram_ctrl_pkg::port_mask_t                              req_push_i,
   input  sdram_ctrl_pkg::port_mask_t                              req_we_i,
   input  sdram_ctrl_pkg::be_t [sdram_ctrl_pkg::NUM_PORTS-1:0]       req_be_i,
   input  sdram_ctrl_pkg::word_adr_t [sdram_ctrl_pkg::NUM_PORTS-1:0] req_adr_i,
   input  sdram_ctrl_pkg::word_t [sdram_ctrl_pkg::NUM_PORTS-1:0]     req_dat_i,
   output sdram_ctrl_pkg::port_mask_t                              queue_full_o,
   output sdram_ctrl_pkg::port_mask_t                              rsp_valid_o,
   output sdram_ctrl_pkg::word_t                                   rsp_dat_o,
   output sdram_ctrl_pkg::bank_t                                   ba_pad_o,
   output sdram_ctrl_pkg::sdram_addr_t                             a_pad_o,
   output logic                                                    cs_n_pad_o,
   output logic                                                    ras_pad_o,
   output logic                                                    cas_pad_o,
   output logic                                                    we_pad_o,
   output logic                                                    cke_pad_o,
   output sdram_ctrl_pkg::dqm_t                                    dqm_pad_o,
   output sdram_ctrl_pkg::dq_t                                     dq_o,
   input  sdram_ctrl_pkg::dq_t                                     dq_i,
   output logic                                                    dq_oe_o
);
   import sdram_ctrl_pkg::*;

   port_mask_t queue_empty;
   port_mask_t head_we;
   port_mask_t pop;
   be_t        head_be  [NUM_PORTS];
   word_adr_t  head_adr [NUM_PORTS];
   word_t      head_dat [NUM_PORTS];
   port_id_t   sel_port;
   logic       wr_load;
   logic       rd_issue;
   sdram_cmd_t cmd;

   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_queue
      req_queue u_queue (
         .sdram_clk  (sdram_clk),
         .sdram_rst  (sdram_rst),
         .push_i     (req_push_i[p]),
         .we_i       (req_we_i[p]),
         .be_i       (req_be_i[p]),
         .adr_i      (req_adr_i[p]),
         .dat_i      (req_dat_i[p]),
         .pop_i      (pop[p]),
         .empty_o    (queue_empty[p]),
         .full_o     (queue_full_o[p]),
         .head_we_o  (head_we[p]),
         .head_be_o  (head_be[p]),
         .head_adr_o (head_adr[p]),
         .head_dat_o (head_dat[p])
      );
   end

   sdram_sequencer u_sequencer (
      .sdram_clk     (sdram_clk),
      .sdram_rst     (sdram_rst),
      .queue_empty_i (queue_empty),
      .head_we_i     (head_we[sel_port]),
      .head_adr_i    (head_adr[sel_port]),
      .pop_o         (pop),
      .sel_port_o    (sel_port),
      .wr_load_o     (wr_load),
      .rd_issue_o    (rd_issue),
      .cmd_o         (cmd),
      .ba_o          (ba_pad_o),
      .a_o           (a_pad_o)
   );

   sdram_datapath u_datapath (
      .sdram_clk   (sdram_clk),
      .sdram_rst   (sdram_rst),
      .wr_load_i   (wr_load),
      .wr_dat_i    (head_dat[sel_port]),
      .wr_be_i     (head_be[sel_port]),
      .rd_issue_i  (rd_issue),
      .rd_port_i   (sel_port),
      .dq_i        (dq_i),
      .dq_o        (dq_o),
      .dq_oe_o     (dq_oe_o),
      .dqm_o       (dqm_pad_o),
      .rsp_valid_o (rsp_valid_o),
      .rsp_dat_o   (rsp_dat_o)
   );

   assign {ras_pad_o, cas_pad_o, we_pad_o} = cmd;

   // Single device, always selected and clocked
   assign cs_n_pad_o = 1'b0;
   assign cke_pad_o  = 1'b1;

endmodule

/* sim/sdram_mem_model.sv */
`timescale 1ns/1ps

module sdram_mem_model (
   input  logic                        sdram_clk,
   input  logic                        cs_n_i,
   input  logic                        ras_n_i,
   input  logic                        cas_n_i,
   input  logic                        we_n_i,
   input  sdram_ctrl_pkg::bank_t       ba_i,
   input  sdram_ctrl_pkg::sdram_addr_t a_i,
   input  sdram_ctrl_pkg::dqm_t        dqm_i,
   input  sdram_ctrl_pkg::dq_t         dq_i,
   input  logic                        dq_oe_i,
   output sdram_ctrl_pkg::dq_t         dq_o
);
   import sdram_ctrl_pkg::*;

   dq_t         mem [logic [23:0]];
   row_t        open_row [4];
   sdram_cmd_t  cmd;
   logic [23:0] key;
   logic        wr2_pend;
   logic [23:0] wr2_key;
   logic        rd1_vld;
   logic        rd2_vld;
   logic [23:0] rd1_key;
   logic [23:0] rd2_key;

   // Unwritten locations read back as zero
   function automatic dq_t read_beat(logic [23:0] k);
      if (mem.exists(k)) begin
         return mem[k];
      end
      return '0;
   endfunction

   // Byte lanes with dqm high keep their old contents
   task automatic write_beat(logic [23:0] k);
      dq_t old;
      old = read_beat(k);
      if (dq_oe_i) begin
         if (!dqm_i[0]) begin
            old[7:0] = dq_i[7:0];
         end
         if (!dqm_i[1]) begin
            old[15:8] = dq_i[15:8];
         end
         mem[k] = old;
      end
   endtask

   initial begin
      dq_o     = '0;
      wr2_pend = 1'b0;
      rd1_vld  = 1'b0;
      rd2_vld  = 1'b0;
   end

   always @(posedge sdram_clk) begin
      cmd = cs_n_i ? CMD_NOP : sdram_cmd_t'({ras_n_i, cas_n_i, we_n_i});
      key = {ba_i, open_row[ba_i], a_i[8:0]};
      if (wr2_pend) begin
         write_beat(wr2_key);
      end
      wr2_pend <= 1'b0;
      case (cmd)
         CMD_ACTIVE: open_row[ba_i] <= a_i;
         CMD_WRITE: begin
            write_beat(key);
            wr2_pend <= 1'b1;
            wr2_key  <= key + 24'd1;
         end
         default: ;
      endcase
      // CAS latency 2, two beats
      rd1_vld <= (cmd == CMD_READ);
      rd1_key <= key;
      rd2_vld <= rd1_vld;
      rd2_key <= rd1_key;
      if (rd1_vld) begin
         dq_o <= read_beat(rd1_key);
      end else if (rd2_vld) begin
         dq_o <= read_beat(rd2_key + 24'd1);
      end else begin
         dq_o <= '0;
      end
   end

endmodule

/* sim/tb_sdram_ctrl.sv */
`timescale 1ns/1ps

module tb_sdram_ctrl;
   import sdram_ctrl_pkg::*;

   localparam int    MAX_VEC   = 32;
   localparam int    FIELDS    = 7;
   localparam string VEC_FILE  = "sim/tb_input_vectors.txt";

   logic                        sdram_clk;
   logic                        sdram_rst;
   port_mask_t                  req_push;
   port_mask_t                  req_we;
   be_t [NUM_PORTS-1:0]         req_be;
   word_adr_t [NUM_PORTS-1:0]   req_adr;
   word_t [NUM_PORTS-1:0]       req_dat;
   port_mask_t                  queue_full;
   port_mask_t                  rsp_valid;
   word_t                       rsp_dat;
   bank_t                       ba_pad;
   sdram_addr_t                 a_pad;
   logic                        cs_n_pad;
   logic                        ras_pad;
   logic                        cas_pad;
   logic                        we_pad;
   logic                        cke_pad;
   dqm_t                        dqm_pad;
   dq_t                         dq_to_mem;
   dq_t                         dq_from_mem;
   logic                        dq_oe;

   logic [31:0] vec_mem [FIELDS*MAX_VEC];
   int          num_vec;
   int          cycle_limit;
   integer      seed;
   port_id_t    exp_port [$];
   word_t       exp_dat [$];
   port_mask_t  full_watch;

   sdram_ctrl_top uut (
      .sdram_clk    (sdram_clk),
      .sdram_rst    (sdram_rst),
      .req_push_i   (req_push),
      .req_we_i     (req_we),
      .req_be_i     (req_be),
      .req_adr_i    (req_adr),
      .req_dat_i    (req_dat),
      .queue_full_o (queue_full),
      .rsp_valid_o  (rsp_valid),
      .rsp_dat_o    (rsp_dat),
      .ba_pad_o     (ba_pad),
      .a_pad_o      (a_pad),
      .cs_n_pad_o   (cs_n_pad),
      .ras_pad_o    (ras_pad),
      .cas_pad_o    (cas_pad),
      .we_pad_o     (we_pad),
      .cke_pad_o    (cke_pad),
      .dqm_pad_o    (dqm_pad),
      .dq_o         (dq_to_mem),
      .dq_i         (dq_from_mem),
      .dq_oe_o      (dq_oe)
   );

   sdram_mem_model u_mem (
      .sdram_clk (sdram_clk),
      .cs_n_i    (cs_n_pad),
      .ras_n_i   (ras_pad),
      .cas_n_i   (cas_pad),
      .we_n_i    (we_pad),
      .ba_i      (ba_pad),
      .a_i       (a_pad),
      .dqm_i     (dqm_pad),
      .dq_i      (dq_to_mem),
      .dq_oe_i   (dq_oe),
      .dq_o      (dq_from_mem)
   );

   always #20 sdram_clk = ~sdram_clk;

   task automatic abort_run(string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_word(word_t act, word_t exp, string what);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, act, exp));
      end
   endtask

   task automatic check_port(port_mask_t act, port_mask_t exp, string what);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, act, exp));
      end
   endtask

   task automatic check_cmd(sdram_cmd_t act, sdram_cmd_t exp, string what);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH at %0t ns: %s is %s, expected %s",
                             $time, what, act.name(), exp.name()));
      end
   endtask

   task automatic check_addr(sdram_addr_t act, sdram_addr_t exp, string what);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, act, exp));
      end
   endtask

   task automatic check_level(logic act, logic exp, string what);
      if (act !== exp) begin
         abort_run($sformatf("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, act, exp));
      end
   endtask

   function automatic logic [31:0] field(int v, int f);
      return vec_mem[v*FIELDS + f];
   endfunction

   // Put one vector on its port, push strobe included
   task automatic drive_request(int v);
      port_id_t p;
      p             = port_id_t'(field(v, 1));
      req_push[p]   = 1'b1;
      req_we[p]     = vec_mem[v*FIELDS + 2][0];
      req_be[p]     = be_t'(field(v, 3));
      req_adr[p]    = word_adr_t'(field(v, 4));
      req_dat[p]    = field(v, 5);
   endtask

   task automatic expect_response(int v);
      exp_port.push_back(port_id_t'(field(v, 1)));
      exp_dat.push_back(field(v, 6));
   endtask

   task automatic wait_responses();
      while (exp_port.size() != 0) begin
         @(posedge sdram_clk);
      end
   endtask

   task automatic run_single(int v);
      expect_response(v);
      @(posedge sdram_clk);
      #1;
      drive_request(v);
      @(posedge sdram_clk);
      #1;
      req_push = '0;
      wait_responses();
   endtask

   // Same-port lines go out in consecutive cycles, service is lowest port first
   task automatic run_batch(int first, int last);
      int slot_of [MAX_VEC];
      int per_port [NUM_PORTS];
      int max_slot;
      port_id_t p;
      max_slot = 0;
      for (int k = 0; k < NUM_PORTS; k++) begin
         per_port[k] = 0;
      end
      for (int v = first; v < last; v++) begin
         p = port_id_t'(field(v, 1));
         slot_of[v] = per_port[p];
         per_port[p]++;
         if (slot_of[v] > max_slot) begin
            max_slot = slot_of[v];
         end
      end
      for (int k = 0; k < NUM_PORTS; k++) begin
         for (int v = first; v < last; v++) begin
            if (field(v, 1) == k) begin
               expect_response(v);
            end
         end
      end
      for (int s = 0; s <= max_slot; s++) begin
         @(posedge sdram_clk);
         #1;
         req_push = '0;
         for (int v = first; v < last; v++) begin
            if (slot_of[v] == s) begin
               drive_request(v);
            end
         end
      end
      @(posedge sdram_clk);
      #1;
      req_push = '0;
      for (int k = 0; k < NUM_PORTS; k++) begin
         if (per_port[k] == QUEUE_DEPTH) begin
            check_port(queue_full & (port_mask_t'(1) << k), port_mask_t'(1) << k,
                       "queue_full_o after filling a queue");
            full_watch[k] = 1'b1;
         end
      end
      wait_responses();
   endtask

   // Pad command watch, responses and timeout, sampled mid-cycle
   initial begin
      int         cycles;
      int         init_seen;
      int         since_ref;
      sdram_cmd_t cmd;
      sdram_cmd_t init_seq [4];
      port_id_t   p;
      logic       prev_write;
      cycles      = 0;
      init_seen   = 0;
      since_ref   = 0;
      prev_write  = 1'b0;
      init_seq[0] = CMD_PRECHARGE;
      init_seq[1] = CMD_AUTO_REFRESH;
      init_seq[2] = CMD_AUTO_REFRESH;
      init_seq[3] = CMD_LOAD_MODE;
      forever begin
         @(negedge sdram_clk);
         cycles++;
         if (cycles > cycle_limit) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
         end
         if (!sdram_rst) begin
            cmd = sdram_cmd_t'({ras_pad, cas_pad, we_pad});
            check_level(cke_pad, 1'b1, "cke_pad_o");
            check_level(cs_n_pad, 1'b0, "cs_n_pad_o");
            // Data bus driven for the WRITE cycle and the beat after it
            check_level(dq_oe, cmd == CMD_WRITE || prev_write, "dq_oe_o");
            prev_write = (cmd == CMD_WRITE);
            if (init_seen < 4 && cmd != CMD_NOP) begin
               check_cmd(cmd, init_seq[init_seen], "init command");
               if (cmd == CMD_LOAD_MODE) begin
                  check_addr(a_pad, MODE_WORD, "mode word on address pad");
               end
               init_seen++;
            end
            if (init_seen == 4) begin
               since_ref = (cmd == CMD_AUTO_REFRESH) ? 0 : since_ref + 1;
               if (since_ref > REF_INTERVAL + 20) begin
                  abort_run("No AUTO REFRESH was issued within the refresh interval");
               end
            end
            if (rsp_valid != '0) begin
               if (exp_port.size() == 0) begin
                  abort_run($sformatf("Unexpected response at %0t ns", $time));
               end
               p = exp_port.pop_front();
               check_port(rsp_valid, port_mask_t'(1) << p, "rsp_valid_o");
               check_word(rsp_dat, exp_dat.pop_front(), "rsp_dat_o");
               if (full_watch[p]) begin
                  check_port(queue_full & (port_mask_t'(1) << p), '0,
                             "queue_full_o after first response");
                  full_watch[p] = 1'b0;
               end
            end
         end
      end
   end

   initial begin
      int v;
      int last;
      sdram_clk   = 1'b0;
      sdram_rst   = 1'b1;
      req_push    = '0;
      req_we      = '0;
      req_be      = '0;
      req_adr     = '0;
      req_dat     = '0;
      full_watch  = '0;
      seed        = 82;
      cycle_limit = 1000000;
      for (int i = 0; i < FIELDS*MAX_VEC; i++) begin
         vec_mem[i] = 32'hFFFF_0000 | i;
      end
      $readmemh(VEC_FILE, vec_mem);
      num_vec = 0;
      while (num_vec < MAX_VEC && vec_mem[num_vec*FIELDS][31:16] != 16'hFFFF) begin
         num_vec++;
      end
      if (num_vec == 0) begin
         abort_run("No vectors could be read from the input file");
      end
      cycle_limit = INIT_WAIT + 60*num_vec + 2*REF_INTERVAL;

      repeat (2) @(posedge sdram_clk);
      #1;
      sdram_rst = 1'b0;

      v = 0;
      while (v < num_vec) begin
         if (field(v, 0) == 0) begin
            run_single(v);
            v++;
         end else begin
            last = v;
            while (last < num_vec && field(last, 0) == field(v, 0)) begin
               last++;
            end
            run_batch(v, last);
            v = last;
         end
         repeat ($random(seed) & 3) @(posedge sdram_clk);
      end

      // Idle long enough for the refresh watch to see a full interval
      repeat (REF_INTERVAL + 40) @(posedge sdram_clk);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* sdram_ctrl_top.f */
logic/sdram_ctrl_pkg.sv
logic/req_queue.sv
logic/sdram_sequencer.sv
logic/sdram_datapath.sv
logic/sdram_ctrl_top.sv
sim/sdram_mem_model.sv
sim/tb_sdram_ctrl.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sdram_ctrl_top.f \
   --top-module tb_sdram_ctrl -o tb_sim

sim_out=$(./obj_dir/tb_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "ALL CHECKS PASSED"; then
   exit 0
else
   exit 1
fi

/* sim/tb_input_vectors.txt */
// grp port we be adr data expected ; grp 0 is a single request,
// lines with the same nonzero grp are queued together while the controller is busy
0 0 1 F 000010 11223344 00000000
0 0 0 0 000010 00000000 11223344
0 1 1 F 412345 A5A55A5A 00000000
0 2 0 0 412345 00000000 A5A55A5A
0 1 1 5 000010 FFFFFFFF 00000000
0 1 0 0 000010 00000000 11FF33FF
0 3 1 C 7FFFFF 01020304 00000000
0 3 0 0 7FFFFF 00000000 01020000
0 2 1 3 412345 DEADBEEF 00000000
0 2 0 0 412345 00000000 A5A5BEEF
1 3 0 0 000010 00000000 11FF33FF
1 3 1 F 000020 CAFEF00D 00000000
1 3 0 0 000020 00000000 CAFEF00D
1 3 0 0 412345 00000000 A5A5BEEF
1 2 0 0 7FFFFF 00000000 01020000
1 1 1 F 000030 12345678 00000000
1 0 0 0 000030 00000000 00000000
0 1 0 0 000030 00000000 12345678
